/* source/ccu_bus_pkg.sv */
// Memory-side bus encodings shared by the write path
package ccu_bus_pkg;

    // Burst kind on the memory AW channel
    typedef logic [1:0] burst_t;

    // Incrementing burst, used for the master's own write
    localparam burst_t BURST_INCR = 2'b01;
    // Wrapping burst, used for a cache line write-back
    localparam burst_t BURST_WRAP = 2'b10;

    // Write response code on the B channels
    typedef logic [1:0] resp_t;

    // Normal completion
    localparam resp_t RESP_OKAY   = 2'b00;
    // Slave error, returned for an illegal snoop code
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

/* source/ccu_snoop_pkg.sv */
// Snoop-side encodings: master AW snoop codes, AC codes and CR bits
package ccu_snoop_pkg;

    // Snoop code on the master AW channel
    typedef logic [2:0] awsnoop_t;

    // Partial line write, other copies must be cleaned
    localparam awsnoop_t WR_UNIQUE      = 3'b000;
    // Full line write, other copies can simply be dropped
    localparam awsnoop_t WR_LINE_UNIQUE = 3'b001;

    // Snoop code on the AC channel
    typedef logic [3:0] acsnoop_t;

    // Write back dirty data and invalidate
    localparam acsnoop_t AC_CLEAN_INVALID = 4'b1001;
    // Invalidate without data
    localparam acsnoop_t AC_MAKE_INVALID  = 4'b1101;

    // Snoop response on the CR channel
    typedef logic [4:0] crresp_t;

    // Snooped cache returns data on CD
    localparam int CR_DATA_TRANSFER = 0;
    // Snooped cache flags an error with the data
    localparam int CR_ERROR         = 1;

endpackage

/* source/ccu_spill_reg.sv */
`timescale 1ns/1ps

// One-entry register slice on a valid/ready channel
module ccu_spill_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    // Upstream side
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    // Downstream side
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     full_q;
    payload_t data_q;

    // Room when empty or when the entry leaves this cycle
    assign in_ready_o  = !full_q || out_ready_i;
    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

    // Occupancy flag
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            full_q <= 1'b1;
        end else if (out_ready_i) begin
            // Drained with nothing new behind it
            full_q <= 1'b0;
        end
    end

    // Payload storage
    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

endmodule

/* source/ccu_wr_snoop_ctrl.sv */
`timescale 1ns/1ps

// Coherent write sequencer: snoop, optional write-back, then the master's write
module ccu_wr_snoop_ctrl #(
    parameter int ADDR_W     = 32,
    parameter int DATA_W     = 64,
    parameter int ID_W       = 4,
    parameter int LINE_BEATS = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // Master AW after the slice
    input  logic                     aw_valid_i,
    output logic                     aw_ready_o,
    input  logic [ID_W-1:0]          aw_id_i,
    input  logic [ADDR_W-1:0]        aw_addr_i,
    input  logic [7:0]               aw_len_i,
    input  ccu_snoop_pkg::awsnoop_t  aw_snoop_i,
    // Master W
    input  logic                     s_w_valid_i,
    output logic                     s_w_ready_o,
    input  logic [DATA_W-1:0]        s_w_data_i,
    input  logic [DATA_W/8-1:0]      s_w_strb_i,
    input  logic                     s_w_last_i,
    // Master B
    output logic                     s_b_valid_o,
    input  logic                     s_b_ready_i,
    output logic [ID_W-1:0]          s_b_id_o,
    output ccu_bus_pkg::resp_t       s_b_resp_o,
    // Snoop AC
    output logic                     ac_valid_o,
    input  logic                     ac_ready_i,
    output logic [ADDR_W-1:0]        ac_addr_o,
    output ccu_snoop_pkg::acsnoop_t  ac_snoop_o,
    // Snoop CR
    input  logic                     cr_valid_i,
    output logic                     cr_ready_o,
    input  ccu_snoop_pkg::crresp_t   cr_resp_i,
    // Snoop CD after the slice
    input  logic                     cd_valid_i,
    output logic                     cd_ready_o,
    input  logic [DATA_W-1:0]        cd_data_i,
    input  logic                     cd_last_i,
    // Memory AW
    output logic                     m_aw_valid_o,
    input  logic                     m_aw_ready_i,
    output logic [ID_W-1:0]          m_aw_id_o,
    output logic [ADDR_W-1:0]        m_aw_addr_o,
    output logic [7:0]               m_aw_len_o,
    output ccu_bus_pkg::burst_t      m_aw_burst_o,
    // Memory W
    output logic                     m_w_valid_o,
    input  logic                     m_w_ready_i,
    output logic [DATA_W-1:0]        m_w_data_o,
    output logic [DATA_W/8-1:0]      m_w_strb_o,
    output logic                     m_w_last_o,
    // Memory B
    input  logic                     m_b_valid_i,
    output logic                     m_b_ready_o,
    input  logic [ID_W-1:0]          m_b_id_i,
    input  ccu_bus_pkg::resp_t       m_b_resp_i
);

    // Byte offset bits inside one cache line
    localparam int LINE_OFFS = $clog2(LINE_BEATS * DATA_W / 8);

    typedef enum logic [2:0] {
        SNOOP_REQ,
        SNOOP_RESP,
        WRITE_CD,
        DRAIN_CD,
        WRITE_W,
        ERR_W,
        ERR_B
    } state_t;

    state_t state_q, state_d;
    logic   ac_valid_q, ac_valid_d;
    logic   m_aw_valid_q, m_aw_valid_d;

    // Held AW and its decoded snoop
    logic [ID_W-1:0]         aw_id_q;
    logic [ADDR_W-1:0]       aw_addr_q;
    logic [7:0]              aw_len_q;
    ccu_snoop_pkg::acsnoop_t ac_snoop_q;

    ccu_snoop_pkg::acsnoop_t ac_snoop_dec;
    logic                    snoop_legal;
    logic [ADDR_W-1:0]       line_addr;

    // Map the master's snoop code onto an AC code
    always_comb begin
        snoop_legal  = 1'b1;
        ac_snoop_dec = ccu_snoop_pkg::AC_CLEAN_INVALID;
        case (aw_snoop_i)
            ccu_snoop_pkg::WR_UNIQUE: begin
                ac_snoop_dec = ccu_snoop_pkg::AC_CLEAN_INVALID;
            end
            ccu_snoop_pkg::WR_LINE_UNIQUE: begin
                ac_snoop_dec = ccu_snoop_pkg::AC_MAKE_INVALID;
            end
            default: begin
                snoop_legal = 1'b0;
            end
        endcase
    end

    // Control state
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= SNOOP_REQ;
            ac_valid_q   <= 1'b0;
            m_aw_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            ac_valid_q   <= ac_valid_d;
            m_aw_valid_q <= m_aw_valid_d;
        end
    end

    // AW holder, loaded on every accepted AW
    always_ff @(posedge clk_i) begin
        if (aw_valid_i && aw_ready_o) begin
            aw_id_q    <= aw_id_i;
            aw_addr_q  <= aw_addr_i;
            aw_len_q   <= aw_len_i;
            ac_snoop_q <= ac_snoop_dec;
        end
    end

    // Line-aligned address for the snoop and the write-back
    assign line_addr = {aw_addr_q[ADDR_W-1:LINE_OFFS], {LINE_OFFS{1'b0}}};

    assign ac_valid_o = ac_valid_q;
    assign ac_addr_o  = line_addr;
    assign ac_snoop_o = ac_snoop_q;

    // Memory AW: a wrapping line burst in WRITE_CD, the held AW otherwise
    assign m_aw_valid_o = m_aw_valid_q;
    assign m_aw_id_o    = aw_id_q;
    assign m_aw_addr_o  = (state_q == WRITE_CD) ? line_addr : aw_addr_q;
    assign m_aw_len_o   = (state_q == WRITE_CD) ? 8'(LINE_BEATS - 1) : aw_len_q;
    assign m_aw_burst_o = (state_q == WRITE_CD) ? ccu_bus_pkg::BURST_WRAP
                                                : ccu_bus_pkg::BURST_INCR;

    always_comb begin
        state_d      = state_q;
        ac_valid_d   = ac_valid_q;
        // Memory AW drops once accepted
        m_aw_valid_d = m_aw_valid_q && !m_aw_ready_i;

        aw_ready_o  = 1'b0;
        cr_ready_o  = 1'b0;
        cd_ready_o  = 1'b0;
        s_w_ready_o = 1'b0;
        s_b_valid_o = 1'b0;
        s_b_id_o    = aw_id_q;
        s_b_resp_o  = m_b_resp_i;
        m_b_ready_o = 1'b0;
        // Memory W defaults to the master's W
        m_w_valid_o = 1'b0;
        m_w_data_o  = s_w_data_i;
        m_w_strb_o  = s_w_strb_i;
        m_w_last_o  = s_w_last_i;

        case (state_q)
            SNOOP_REQ: begin
                // Idle until an AW is taken, then hold AC until accepted
                aw_ready_o = !ac_valid_q;
                if (ac_valid_q) begin
                    if (ac_ready_i) begin
                        ac_valid_d = 1'b0;
                        state_d    = SNOOP_RESP;
                    end
                end else if (aw_valid_i) begin
                    if (snoop_legal) begin
                        ac_valid_d = 1'b1;
                    end else begin
                        state_d = ERR_W;
                    end
                end
            end
            SNOOP_RESP: begin
                cr_ready_o = 1'b1;
                if (cr_valid_i) begin
                    if (cr_resp_i[ccu_snoop_pkg::CR_DATA_TRANSFER]
                        && !cr_resp_i[ccu_snoop_pkg::CR_ERROR]) begin
                        // Dirty line, write it back first
                        state_d      = WRITE_CD;
                        m_aw_valid_d = 1'b1;
                    end else if (cr_resp_i[ccu_snoop_pkg::CR_DATA_TRANSFER]) begin
                        // Data comes with an error, throw it away
                        state_d = DRAIN_CD;
                    end else begin
                        state_d      = WRITE_W;
                        m_aw_valid_d = 1'b1;
                    end
                end
            end
            WRITE_CD: begin
                // Snooped beats go out with full strobes
                m_w_valid_o = cd_valid_i;
                m_w_data_o  = cd_data_i;
                m_w_strb_o  = '1;
                m_w_last_o  = cd_last_i;
                cd_ready_o  = m_w_ready_i;
                // Write-back B stays inside
                m_b_ready_o = 1'b1;
                if (m_b_valid_i) begin
                    state_d      = WRITE_W;
                    m_aw_valid_d = 1'b1;
                end
            end
            DRAIN_CD: begin
                cd_ready_o = 1'b1;
                if (cd_valid_i && cd_last_i) begin
                    state_d      = WRITE_W;
                    m_aw_valid_d = 1'b1;
                end
            end
            WRITE_W: begin
                // Master W through to memory
                m_w_valid_o = s_w_valid_i;
                s_w_ready_o = m_w_ready_i;
                // Memory B back to the master
                s_b_valid_o = m_b_valid_i;
                s_b_id_o    = m_b_id_i;
                m_b_ready_o = s_b_ready_i;
                if (m_b_valid_i && s_b_ready_i) begin
                    state_d = SNOOP_REQ;
                end
            end
            ERR_W: begin
                // Swallow the beats of an illegal write
                s_w_ready_o = 1'b1;
                if (s_w_valid_i && s_w_last_i) begin
                    state_d = ERR_B;
                end
            end
            ERR_B: begin
                s_b_valid_o = 1'b1;
                s_b_resp_o  = ccu_bus_pkg::RESP_SLVERR;
                if (s_b_ready_i) begin
                    state_d = SNOOP_REQ;
                end
            end
            default: begin
                state_d = SNOOP_REQ;
            end
        endcase
    end

endmodule

/* source/ccu_wr_top.sv */
`timescale 1ns/1ps

// Write path of the coherency unit: AW and CD slices around the controller
module ccu_wr_top #(
    parameter int ADDR_W     = 32,
    parameter int DATA_W     = 64,
    parameter int ID_W       = 4,
    parameter int LINE_BEATS = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // Master AW
    input  logic                     s_aw_valid_i,
    output logic                     s_aw_ready_o,
    input  logic [ID_W-1:0]          s_aw_id_i,
    input  logic [ADDR_W-1:0]        s_aw_addr_i,
    input  logic [7:0]               s_aw_len_i,
    input  ccu_snoop_pkg::awsnoop_t  s_aw_snoop_i,
    // Master W
    input  logic                     s_w_valid_i,
    output logic                     s_w_ready_o,
    input  logic [DATA_W-1:0]        s_w_data_i,
    input  logic [DATA_W/8-1:0]      s_w_strb_i,
    input  logic                     s_w_last_i,
    // Master B
    output logic                     s_b_valid_o,
    input  logic                     s_b_ready_i,
    output logic [ID_W-1:0]          s_b_id_o,
    output ccu_bus_pkg::resp_t       s_b_resp_o,
    // Snoop AC
    output logic                     ac_valid_o,
    input  logic                     ac_ready_i,
    output logic [ADDR_W-1:0]        ac_addr_o,
    output ccu_snoop_pkg::acsnoop_t  ac_snoop_o,
    // Snoop CR
    input  logic                     cr_valid_i,
    output logic                     cr_ready_o,
    input  ccu_snoop_pkg::crresp_t   cr_resp_i,
    // Snoop CD
    input  logic                     cd_valid_i,
    output logic                     cd_ready_o,
    input  logic [DATA_W-1:0]        cd_data_i,
    input  logic                     cd_last_i,
    // Memory AW
    output logic                     m_aw_valid_o,
    input  logic                     m_aw_ready_i,
    output logic [ID_W-1:0]          m_aw_id_o,
    output logic [ADDR_W-1:0]        m_aw_addr_o,
    output logic [7:0]               m_aw_len_o,
    output ccu_bus_pkg::burst_t      m_aw_burst_o,
    // Memory W
    output logic                     m_w_valid_o,
    input  logic                     m_w_ready_i,
    output logic [DATA_W-1:0]        m_w_data_o,
    output logic [DATA_W/8-1:0]      m_w_strb_o,
    output logic                     m_w_last_o,
    // Memory B
    input  logic                     m_b_valid_i,
    output logic                     m_b_ready_o,
    input  logic [ID_W-1:0]          m_b_id_i,
    input  ccu_bus_pkg::resp_t       m_b_resp_i
);

    // Slice payloads
    typedef struct packed {
        logic [ID_W-1:0]         id;
        logic [ADDR_W-1:0]       addr;
        logic [7:0]              len;
        ccu_snoop_pkg::awsnoop_t snoop;
    } aw_payload_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } cd_payload_t;

    aw_payload_t aw_in, aw_out;
    cd_payload_t cd_in, cd_out;
    logic        aw_valid, aw_ready;
    logic        cd_valid, cd_ready;

    // Pack the outside channels
    assign aw_in.id    = s_aw_id_i;
    assign aw_in.addr  = s_aw_addr_i;
    assign aw_in.len   = s_aw_len_i;
    assign aw_in.snoop = s_aw_snoop_i;
    assign cd_in.data  = cd_data_i;
    assign cd_in.last  = cd_last_i;

    // Holds one AW while the controller is busy
    ccu_spill_reg #(
        .payload_t (aw_payload_t)
    ) u_aw_slice (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (s_aw_valid_i),
        .in_ready_o  (s_aw_ready_o),
        .in_data_i   (aw_in),
        .out_valid_o (aw_valid),
        .out_ready_i (aw_ready),
        .out_data_o  (aw_out)
    );

    // Snoop data slice
    ccu_spill_reg #(
        .payload_t (cd_payload_t)
    ) u_cd_slice (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (cd_valid_i),
        .in_ready_o  (cd_ready_o),
        .in_data_i   (cd_in),
        .out_valid_o (cd_valid),
        .out_ready_i (cd_ready),
        .out_data_o  (cd_out)
    );

    ccu_wr_snoop_ctrl #(
        .ADDR_W     (ADDR_W),
        .DATA_W     (DATA_W),
        .ID_W       (ID_W),
        .LINE_BEATS (LINE_BEATS)
    ) u_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .aw_valid_i   (aw_valid),
        .aw_ready_o   (aw_ready),
        .aw_id_i      (aw_out.id),
        .aw_addr_i    (aw_out.addr),
        .aw_len_i     (aw_out.len),
        .aw_snoop_i   (aw_out.snoop),
        .s_w_valid_i  (s_w_valid_i),
        .s_w_ready_o  (s_w_ready_o),
        .s_w_data_i   (s_w_data_i),
        .s_w_strb_i   (s_w_strb_i),
        .s_w_last_i   (s_w_last_i),
        .s_b_valid_o  (s_b_valid_o),
        .s_b_ready_i  (s_b_ready_i),
        .s_b_id_o     (s_b_id_o),
        .s_b_resp_o   (s_b_resp_o),
        .ac_valid_o   (ac_valid_o),
        .ac_ready_i   (ac_ready_i),
        .ac_addr_o    (ac_addr_o),
        .ac_snoop_o   (ac_snoop_o),
        .cr_valid_i   (cr_valid_i),
        .cr_ready_o   (cr_ready_o),
        .cr_resp_i    (cr_resp_i),
        .cd_valid_i   (cd_valid),
        .cd_ready_o   (cd_ready),
        .cd_data_i    (cd_out.data),
        .cd_last_i    (cd_out.last),
        .m_aw_valid_o (m_aw_valid_o),
        .m_aw_ready_i (m_aw_ready_i),
        .m_aw_id_o    (m_aw_id_o),
        .m_aw_addr_o  (m_aw_addr_o),
        .m_aw_len_o   (m_aw_len_o),
        .m_aw_burst_o (m_aw_burst_o),
        .m_w_valid_o  (m_w_valid_o),
        .m_w_ready_i  (m_w_ready_i),
        .m_w_data_o   (m_w_data_o),
        .m_w_strb_o   (m_w_strb_o),
        .m_w_last_o   (m_w_last_o),
        .m_b_valid_i  (m_b_valid_i),
        .m_b_ready_o  (m_b_ready_o),
        .m_b_id_i     (m_b_id_i),
        .m_b_resp_i   (m_b_resp_i)
    );

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

// Free-running clock and a reset held low for the first two cycles
module tb_clk_gen #(
    parameter int HALF_PERIOD = 10
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Release 1 ns after the second rising edge
    initial begin
        rst_no <= 1'b0;
        repeat (2) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

/* tb/tb_ccu_wr.sv */
`timescale 1ns/1ps

module tb_ccu_wr;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int ID_W = 4;
    localparam int LINE_BEATS = 4;
    localparam int NUM_WRITES = 40;
    // About 60 cycles per write
    localparam int MAX_CYCLES = NUM_WRITES * 60;
    localparam logic [ADDR_W-1:0] LINE_MASK = ~32'h1f;

    logic clk_i, rst_ni;
    logic s_aw_valid_i, s_aw_ready_o, s_w_valid_i, s_w_ready_o, s_w_last_i;
    logic [ID_W-1:0] s_aw_id_i, s_b_id_o, m_aw_id_o, m_b_id_i;
    logic [ADDR_W-1:0] s_aw_addr_i, ac_addr_o, m_aw_addr_o;
    logic [7:0] s_aw_len_i, m_aw_len_o;
    ccu_snoop_pkg::awsnoop_t s_aw_snoop_i;
    logic [DATA_W-1:0] s_w_data_i, cd_data_i, m_w_data_o;
    logic [DATA_W/8-1:0] s_w_strb_i, m_w_strb_o;
    logic s_b_valid_o, s_b_ready_i, ac_valid_o, ac_ready_i, cr_valid_i, cr_ready_o;
    ccu_bus_pkg::resp_t s_b_resp_o, m_b_resp_i;
    ccu_snoop_pkg::acsnoop_t ac_snoop_o;
    ccu_snoop_pkg::crresp_t cr_resp_i;
    logic cd_valid_i, cd_ready_o, cd_last_i;
    logic m_aw_valid_o, m_aw_ready_i, m_w_valid_o, m_w_ready_i, m_w_last_o;
    ccu_bus_pkg::burst_t m_aw_burst_o;
    logic m_b_valid_i, m_b_ready_o;

    // Expected traffic, queued when each write is issued
    logic [ADDR_W+3:0] exp_ac[$];
    logic [ID_W+ADDR_W+9:0] exp_aw[$];
    logic [DATA_W+DATA_W/8:0] exp_w[$];
    logic [ID_W:0] exp_b[$];

    logic [31:0] seed = 32'he601;
    int cycles = 0;

    // Memory model state
    logic [ID_W:0] mem_aw_q[$];
    int mem_last_cnt = 0;
    logic mem_b_wrap = 1'b0;

    // Previous-cycle copies for the stability checks
    logic after_rst = 1'b1;
    logic ac_hold = 1'b0, maw_hold = 1'b0, mw_hold = 1'b0, sb_hold = 1'b0;
    logic [ADDR_W+3:0] ac_prev;
    logic [ID_W+ADDR_W+9:0] maw_prev;
    logic [DATA_W+DATA_W/8:0] mw_prev;
    logic [ID_W+1:0] sb_prev;

    tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

    ccu_wr_top #(
        .ADDR_W(ADDR_W), .DATA_W(DATA_W), .ID_W(ID_W), .LINE_BEATS(LINE_BEATS)
    ) UUT (.*);

    function automatic logic [15:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[30:15];
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        stop_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // Master AW, with a random idle cycle before valid
    task automatic send_aw(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                           input logic [7:0] len, input ccu_snoop_pkg::awsnoop_t snoop);
        if (next_rand() % 2 == 0) begin
            @(posedge clk_i);
            #1;
        end
        s_aw_valid_i = 1'b1;
        s_aw_id_i = id;
        s_aw_addr_i = addr;
        s_aw_len_i = len;
        s_aw_snoop_i = snoop;
        do @(posedge clk_i); while (!s_aw_ready_o);
        #1;
        s_aw_valid_i = 1'b0;
    endtask

    task automatic send_w(input logic [DATA_W+DATA_W/8:0] beats[$]);
        foreach (beats[b]) begin
            s_w_valid_i = 1'b1;
            {s_w_data_i, s_w_strb_i, s_w_last_i} = beats[b];
            do @(posedge clk_i); while (!s_w_ready_o);
            #1;
            s_w_valid_i = 1'b0;
            // Gap between beats now and then
            if (next_rand() % 4 == 0) begin
                @(posedge clk_i);
                #1;
            end
        end
    endtask

    // Snooped cache: take AC, answer CR, then send the line if it has data
    task automatic answer_snoop(input int kind, input logic [DATA_W-1:0] line[LINE_BEATS]);
        forever begin
            ac_ready_i = (next_rand() % 4) != 0;
            @(posedge clk_i);
            if (ac_valid_o && ac_ready_i) break;
            #1;
        end
        #1;
        ac_ready_i = 1'b0;
        cr_valid_i = 1'b1;
        cr_resp_i = '0;
        cr_resp_i[ccu_snoop_pkg::CR_DATA_TRANSFER] = (kind != 0);
        cr_resp_i[ccu_snoop_pkg::CR_ERROR] = (kind == 2);
        do @(posedge clk_i); while (!cr_ready_o);
        #1;
        cr_valid_i = 1'b0;
        if (kind != 0) begin
            for (int b = 0; b < LINE_BEATS; b++) begin
                cd_valid_i = 1'b1;
                cd_data_i = line[b];
                cd_last_i = (b == LINE_BEATS - 1);
                do @(posedge clk_i); while (!cd_ready_o);
                #1;
                cd_valid_i = 1'b0;
            end
        end
    endtask

    task automatic take_b();
        forever begin
            s_b_ready_i = (next_rand() % 3) != 0;
            @(posedge clk_i);
            if (s_b_valid_o && s_b_ready_i) break;
            #1;
        end
        #1;
        s_b_ready_i = 1'b0;
    endtask

    // One coherent write: queue what must be seen, then run all sides
    task automatic run_write();
        logic [ID_W-1:0] id;
        logic [ADDR_W-1:0] addr;
        logic [7:0] len;
        ccu_snoop_pkg::awsnoop_t snoop;
        logic legal;
        int kind;
        logic [DATA_W-1:0] line[LINE_BEATS];
        logic [DATA_W+DATA_W/8:0] beats[$];
        id = ID_W'(next_rand());
        addr = {next_rand(), next_rand()} & ~32'h7;
        len = 8'(next_rand() % 4);
        snoop = (next_rand() % 4 == 0) ? 3'(2 + next_rand() % 6) : 3'(next_rand() % 2);
        legal = (snoop == ccu_snoop_pkg::WR_UNIQUE) || (snoop == ccu_snoop_pkg::WR_LINE_UNIQUE);
        kind = next_rand() % 3;
        for (int b = 0; b < LINE_BEATS; b++) begin
            line[b] = {next_rand(), next_rand(), next_rand(), next_rand()};
        end
        for (int b = 0; b <= len; b++) begin
            beats.push_back({next_rand(), next_rand(), next_rand(), next_rand(),
                             8'(next_rand()), 1'(b == len)});
        end
        if (legal) begin
            exp_ac.push_back({addr & LINE_MASK, (snoop == ccu_snoop_pkg::WR_UNIQUE) ?
                              ccu_snoop_pkg::AC_CLEAN_INVALID : ccu_snoop_pkg::AC_MAKE_INVALID});
            if (kind == 1) begin
                exp_aw.push_back({id, addr & LINE_MASK, 8'(LINE_BEATS - 1),
                                  ccu_bus_pkg::BURST_WRAP});
                for (int b = 0; b < LINE_BEATS; b++) begin
                    exp_w.push_back({line[b], {DATA_W/8{1'b1}}, 1'(b == LINE_BEATS - 1)});
                end
            end
            exp_aw.push_back({id, addr, len, ccu_bus_pkg::BURST_INCR});
            foreach (beats[b]) exp_w.push_back(beats[b]);
        end
        exp_b.push_back({id, legal});
        fork
            send_aw(id, addr, len, snoop);
            send_w(beats);
            if (legal) answer_snoop(kind, line);
        join
        take_b();
    endtask

    // Memory: random readies, one B per completed write
    always @(posedge clk_i) begin
        logic b_taken;
        b_taken = m_b_valid_i && m_b_ready_o;
        if (rst_ni) begin
            if (m_aw_valid_o && m_aw_ready_i) begin
                mem_aw_q.push_back({m_aw_id_o, m_aw_burst_o == ccu_bus_pkg::BURST_WRAP});
            end
            if (m_w_valid_o && m_w_ready_i && m_w_last_o) mem_last_cnt++;
        end
        #1;
        m_aw_ready_i = (next_rand() % 4) != 0;
        m_w_ready_i = (next_rand() % 4) != 0;
        if (b_taken) begin
            m_b_valid_i = 1'b0;
        end else if (!m_b_valid_i && mem_aw_q.size() > 0 && mem_last_cnt > 0) begin
            {m_b_id_i, mem_b_wrap} = mem_aw_q.pop_front();
            mem_last_cnt--;
            m_b_resp_i = (next_rand() % 4 == 0) ? ccu_bus_pkg::RESP_SLVERR
                                                : ccu_bus_pkg::RESP_OKAY;
            m_b_valid_i = 1'b1;
        end
    end

    // Checks, sampled on the rising edge
    always @(posedge clk_i) begin
        logic [ADDR_W+3:0] ac_e;
        logic [ID_W+ADDR_W+9:0] aw_e;
        logic [DATA_W+DATA_W/8:0] w_e;
        logic [ID_W:0] b_e;
        cycles++;
        if (cycles >= MAX_CYCLES) stop_run("Timeout: the writes did not complete in time");
        if (!rst_ni || after_rst) begin
            assert (!ac_valid_o && !cr_ready_o && !s_w_ready_o && !s_b_valid_o)
                else stop_run("Master or snoop handshake output high around reset");
            assert (!m_aw_valid_o && !m_w_valid_o && !m_b_ready_o)
                else stop_run("Memory handshake output high around reset");
            assert (s_aw_ready_o) else stop_run("s_aw_ready_o low around reset");
        end
        after_rst <= !rst_ni;
        if (rst_ni) begin
            // Held valids keep their payload
            if (ac_hold) assert (ac_valid_o && {ac_addr_o, ac_snoop_o} == ac_prev)
                else stop_run("AC request changed before it was accepted");
            if (maw_hold) assert (m_aw_valid_o && {m_aw_id_o, m_aw_addr_o, m_aw_len_o,
                                  m_aw_burst_o} == maw_prev)
                else stop_run("Memory AW changed before it was accepted");
            if (mw_hold) assert (m_w_valid_o && {m_w_data_o, m_w_strb_o, m_w_last_o} == mw_prev)
                else stop_run("Memory W changed before it was accepted");
            if (sb_hold) assert (s_b_valid_o && {s_b_id_o, s_b_resp_o} == sb_prev)
                else stop_run("Master B changed before it was accepted");
            // A stalled memory W holds back the beat behind it
            if (m_w_valid_o && !m_w_ready_i) begin
                assert (!s_w_ready_o)
                    else stop_run("s_w_ready_o high while memory W is stalled");
                if (cd_valid_i) assert (!cd_ready_o)
                    else stop_run("cd_ready_o high while memory W is stalled");
            end
            assert (!(s_b_valid_o && m_b_valid_i && mem_b_wrap))
                else stop_run("Write-back response reached the master");
            if (ac_valid_o) assert (exp_ac.size() > 0)
                else stop_run("Snoop request raised with none expected");
            if (ac_valid_o && ac_ready_i) begin
                ac_e = exp_ac.pop_front();
                assert ({ac_addr_o, ac_snoop_o} == ac_e)
                    else report_mismatch("ac_addr_o/ac_snoop_o", {ac_addr_o, ac_snoop_o}, ac_e);
            end
            if (m_aw_valid_o && m_aw_ready_i) begin
                assert (exp_aw.size() > 0) else stop_run("Unexpected memory AW");
                aw_e = exp_aw.pop_front();
                assert ({m_aw_id_o, m_aw_addr_o, m_aw_len_o, m_aw_burst_o} == aw_e)
                    else report_mismatch("m_aw_id/addr/len/burst",
                                         {m_aw_id_o, m_aw_addr_o, m_aw_len_o, m_aw_burst_o}, aw_e);
            end
            if (m_w_valid_o && m_w_ready_i) begin
                assert (exp_w.size() > 0) else stop_run("Unexpected memory W beat");
                w_e = exp_w.pop_front();
                assert ({m_w_data_o, m_w_strb_o, m_w_last_o} == w_e)
                    else report_mismatch("m_w_data/strb/last",
                                         {m_w_data_o, m_w_strb_o, m_w_last_o}, w_e);
            end
            if (s_b_valid_o && s_b_ready_i) begin
                assert (exp_b.size() > 0) else stop_run("Extra B response to the master");
                b_e = exp_b.pop_front();
                assert (s_b_id_o == b_e[ID_W:1])
                    else report_mismatch("s_b_id_o", s_b_id_o, b_e[ID_W:1]);
                if (b_e[0]) begin
                    assert (s_b_resp_o == m_b_resp_i)
                        else report_mismatch("s_b_resp_o", s_b_resp_o, m_b_resp_i);
                end else begin
                    assert (s_b_resp_o == ccu_bus_pkg::RESP_SLVERR)
                        else report_mismatch("s_b_resp_o", s_b_resp_o, ccu_bus_pkg::RESP_SLVERR);
                end
            end
        end
        ac_hold <= ac_valid_o && !ac_ready_i;
        ac_prev <= {ac_addr_o, ac_snoop_o};
        maw_hold <= m_aw_valid_o && !m_aw_ready_i;
        maw_prev <= {m_aw_id_o, m_aw_addr_o, m_aw_len_o, m_aw_burst_o};
        mw_hold <= m_w_valid_o && !m_w_ready_i;
        mw_prev <= {m_w_data_o, m_w_strb_o, m_w_last_o};
        sb_hold <= s_b_valid_o && !s_b_ready_i;
        sb_prev <= {s_b_id_o, s_b_resp_o};
    end

    initial begin
        s_aw_valid_i = 1'b0;
        s_aw_id_i = '0;
        s_aw_addr_i = '0;
        s_aw_len_i = '0;
        s_aw_snoop_i = '0;
        s_w_valid_i = 1'b0;
        s_w_data_i = '0;
        s_w_strb_i = '0;
        s_w_last_i = 1'b0;
        s_b_ready_i = 1'b0;
        ac_ready_i = 1'b0;
        cr_valid_i = 1'b0;
        cr_resp_i = '0;
        cd_valid_i = 1'b0;
        cd_data_i = '0;
        cd_last_i = 1'b0;
        m_aw_ready_i = 1'b0;
        m_w_ready_i = 1'b0;
        m_b_valid_i = 1'b0;
        m_b_id_i = '0;
        m_b_resp_i = ccu_bus_pkg::RESP_OKAY;
        @(posedge rst_ni);
        @(posedge clk_i);
        #1;
        for (int i = 0; i < NUM_WRITES; i++) run_write();
        repeat (4) @(posedge clk_i);
        // Everything queued must have been seen
        if (exp_ac.size() + exp_aw.size() + exp_w.size() + exp_b.size() != 0) begin
            stop_run("Expected traffic never appeared");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* compile.f */
source/ccu_bus_pkg.sv
source/ccu_snoop_pkg.sv
source/ccu_spill_reg.sv
source/ccu_wr_snoop_ctrl.sv
source/ccu_wr_top.sv
tb/tb_clk_gen.sv
tb/tb_ccu_wr.sv
